/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_lsu_mem
FILELIST  ?= lsu_mem.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= Testbench passed

SOURCES := $(shell cat $(FILELIST))
SIM     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* axi_bank_router.sv */
`timescale 1ns/1ps

module axi_bank_router import lsu_axi_pkg::*, lsu_mem_pkg::*; (
    input  logic                 clk,
    input  logic                 rst,
    input  axi_aw_t              aw,
    input  logic                 aw_valid,
    output logic                 aw_ready,
    input  axi_w_t               w,
    input  logic                 w_valid,
    output logic                 w_ready,
    input  axi_ar_t              ar,
    input  logic                 ar_valid,
    output logic                 ar_ready,
    output axi_aw_t              bank_aw [NUM_BANKS],
    output logic [NUM_BANKS-1:0] bank_aw_valid,
    input  logic [NUM_BANKS-1:0] bank_aw_ready,
    output axi_w_t               bank_w [NUM_BANKS],
    output logic [NUM_BANKS-1:0] bank_w_valid,
    input  logic [NUM_BANKS-1:0] bank_w_ready,
    output axi_ar_t              bank_ar [NUM_BANKS],
    output logic [NUM_BANKS-1:0] bank_ar_valid,
    input  logic [NUM_BANKS-1:0] bank_ar_ready,
    output route_t               route,
    output logic                 route_valid,
    input  logic                 route_done
);

    logic [31:0]           aw_off;
    logic [31:0]           ar_off;
    logic                  aw_hit;
    logic                  ar_hit;
    logic [BANK_IDX_W-1:0] aw_sel;
    logic [BANK_IDX_W-1:0] ar_sel;
    logic                  wr_hs;
    logic                  ar_hs;

    assign aw_off = aw.addr - MEM_BASE;
    assign ar_off = ar.addr - MEM_BASE;
    assign aw_hit = aw_off < MEM_BYTES;     // wraps below base, so one compare is enough
    assign ar_hit = ar_off < MEM_BYTES;
    assign aw_sel = aw_off[BANK_SEL_LSB +: BANK_IDX_W];
    assign ar_sel = ar_off[BANK_SEL_LSB +: BANK_IDX_W];

    always_comb begin
        bank_aw_valid = '0;
        bank_w_valid  = '0;
        bank_ar_valid = '0;
        for (int i = 0; i < NUM_BANKS; i++) begin
            bank_aw[i] = aw;
            bank_w[i]  = w;
            bank_ar[i] = ar;
        end
        if (aw_hit) begin
            bank_aw_valid[aw_sel] = aw_valid;
            bank_w_valid[aw_sel]  = w_valid;
        end
        if (ar_hit) begin
            bank_ar_valid[ar_sel] = ar_valid;
        end
    end

    // unmapped requests are taken here and answered by the merger
    assign aw_ready = aw_hit ? bank_aw_ready[aw_sel] : 1'b1;
    assign w_ready  = aw_hit ? bank_w_ready[aw_sel] : 1'b1;
    assign ar_ready = ar_hit ? bank_ar_ready[ar_sel] : 1'b1;

    assign wr_hs = aw_valid && aw_ready && w_valid && w_ready;
    assign ar_hs = ar_valid && ar_ready;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            route_valid <= 1'b0;
            route       <= '0;
        end else if (wr_hs) begin
            route_valid <= 1'b1;
            route       <= '{dec_err: !aw_hit, bank: aw_sel};
        end else if (ar_hs) begin
            route_valid <= 1'b1;
            route       <= '{dec_err: !ar_hit, bank: ar_sel};
        end else if (route_done) begin
            route_valid <= 1'b0;
        end
    end

    // the lsu must wait for its answer before the next request
    assert property (@(posedge clk) disable iff (rst) route_valid |-> !(wr_hs || ar_hs));

endmodule

/* axi_resp_merge.sv */
`timescale 1ns/1ps

module axi_resp_merge import lsu_axi_pkg::*, lsu_mem_pkg::*; (
    input  logic                 clk,
    input  logic                 rst,
    input  route_t               route,
    input  logic                 route_valid,
    output logic                 route_done,
    input  axi_b_t               bank_b [NUM_BANKS],
    input  logic [NUM_BANKS-1:0] bank_b_valid,
    output logic [NUM_BANKS-1:0] bank_b_ready,
    input  axi_r_t               bank_r [NUM_BANKS],
    input  logic [NUM_BANKS-1:0] bank_r_valid,
    output logic [NUM_BANKS-1:0] bank_r_ready,
    output axi_b_t               b,
    output logic                 b_valid,
    input  logic                 b_ready,
    output axi_r_t               r,
    output logic                 r_valid,
    input  logic                 r_ready
);

    logic                 dec;
    logic                 hit;
    logic [NUM_BANKS-1:0] routed;

    assign dec = route_valid && route.dec_err;
    assign hit = route_valid && !route.dec_err;

    always_comb begin
        routed = '0;
        if (hit) begin
            routed[route.bank] = 1'b1;
        end
    end

    assign bank_b_ready = routed & {NUM_BANKS{b_ready}};
    assign bank_r_ready = routed & {NUM_BANKS{r_ready}};

    // decode error goes out on both channels, the lsu only waits on one
    assign b_valid = dec || |(bank_b_valid & routed);
    assign r_valid = dec || |(bank_r_valid & routed);
    assign b = dec ? axi_b_t'{resp: RESP_DECERR} : bank_b[route.bank];
    assign r = dec ? axi_r_t'{data: 32'h0, resp: RESP_DECERR} : bank_r[route.bank];

    assign route_done = (b_valid && b_ready) || (r_valid && r_ready);

    // only the bank the router picked may be answering
    assert property (@(posedge clk) disable iff (rst)
        ((bank_b_valid | bank_r_valid) & ~routed) == '0);

endmodule

/* axi_sram_bank.sv */
`timescale 1ns/1ps

module axi_sram_bank import lsu_axi_pkg::*, lsu_mem_pkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  axi_aw_t aw,
    input  logic    aw_valid,
    output logic    aw_ready,
    input  axi_w_t  w,
    input  logic    w_valid,
    output logic    w_ready,
    output axi_b_t  b,
    output logic    b_valid,
    input  logic    b_ready,
    input  axi_ar_t ar,
    input  logic    ar_valid,
    output logic    ar_ready,
    output axi_r_t  r,
    output logic    r_valid,
    input  logic    r_ready
);

    logic [31:0]             mem [BANK_WORDS];
    logic [BANK_SEL_LSB-3:0] wr_idx;
    logic [BANK_SEL_LSB-3:0] rd_idx;
    logic                    idle;
    logic                    wr_hs;
    logic                    rd_hs;
    logic                    wr_ok;
    logic                    rd_ok;

    function automatic logic is_aligned(input logic [1:0] lsb, input logic [2:0] size);
        case (size)
            SIZE_BYTE: is_aligned = 1'b1;
            SIZE_HALF: is_aligned = !lsb[0];
            SIZE_WORD: is_aligned = lsb == 2'b00;
            default:   is_aligned = 1'b0;
        endcase
    endfunction

    assign idle     = !b_valid && !r_valid;
    assign aw_ready = idle && w_valid;
    assign w_ready  = idle && aw_valid;
    assign ar_ready = idle && !(aw_valid && w_valid);   // write wins

    assign wr_hs  = aw_valid && aw_ready && w_valid && w_ready;
    assign rd_hs  = ar_valid && ar_ready;
    assign wr_idx = aw.addr[BANK_SEL_LSB-1:2];
    assign rd_idx = ar.addr[BANK_SEL_LSB-1:2];
    assign wr_ok  = is_aligned(aw.addr[1:0], aw.size);
    assign rd_ok  = is_aligned(ar.addr[1:0], ar.size);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            b_valid <= 1'b0;
            r_valid <= 1'b0;
        end else begin
            if (wr_hs) begin
                b_valid <= 1'b1;
            end else if (b_ready) begin
                b_valid <= 1'b0;
            end
            if (rd_hs) begin
                r_valid <= 1'b1;
            end else if (r_ready) begin
                r_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_hs) begin
            for (int i = 0; i < 4; i++) begin
                if (wr_ok && w.strb[i]) begin
                    mem[wr_idx][8*i +: 8] <= w.data[8*i +: 8];
                end
            end
            b.resp <= wr_ok ? RESP_OKAY : RESP_SLVERR;
        end
        if (rd_hs) begin
            r.data <= rd_ok ? mem[rd_idx] : 32'h0;  // write-back picks the byte lane
            r.resp <= rd_ok ? RESP_OKAY : RESP_SLVERR;
        end
    end

    assert property (@(posedge clk) disable iff (rst)
        r_valid && !r_ready |=> r_valid && $stable(r));

endmodule

/* lsu.sv */
`timescale 1ns/1ps

module lsu import lsu_axi_pkg::*, lsu_mem_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  lsu_req_t  req,
    input  logic      req_valid,
    output logic      req_ready,
    output lsu_resp_t resp,
    output logic      resp_valid,
    input  logic      resp_ready,
    output axi_aw_t   aw,
    output logic      aw_valid,
    input  logic      aw_ready,
    output axi_w_t    w,
    output logic      w_valid,
    input  logic      w_ready,
    input  axi_b_t    b,
    input  logic      b_valid,
    output logic      b_ready,
    output axi_ar_t   ar,
    output logic      ar_valid,
    input  logic      ar_ready,
    input  axi_r_t    r,
    input  logic      r_valid,
    output logic      r_ready
);

    typedef enum logic {
        ST_IDLE,
        ST_BUSY
    } state_e;

    state_e      state;
    logic [31:0] addr_q;
    logic [1:0]  offset;
    logic [3:0]  strb_base;
    logic [2:0]  size;
    logic        accept;
    logic        wr_hs;
    logic        ar_hs;
    logic        b_hs;
    logic        r_hs;
    logic        resp_hs;
    logic        r_fault;

    assign accept  = req_valid && req_ready;
    assign wr_hs   = aw_valid && aw_ready && w_valid && w_ready;
    assign ar_hs   = ar_valid && ar_ready;
    assign b_hs    = b_valid && b_ready;
    assign r_hs    = r_valid && r_ready;
    assign resp_hs = resp_valid && resp_ready;
    assign r_fault = r.resp != RESP_OKAY;
    assign offset  = req.addr[1:0];

    always_comb begin
        case (req.width)
            WIDTH_BYTE: begin
                strb_base = 4'b0001;
                size      = SIZE_BYTE;
            end
            WIDTH_HALF: begin
                strb_base = 4'b0011;
                size      = SIZE_HALF;
            end
            default: begin
                strb_base = 4'b1111;
                size      = SIZE_WORD;
            end
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state      <= ST_IDLE;
            req_ready  <= 1'b1;
            resp_valid <= 1'b0;
            aw_valid   <= 1'b0;
            w_valid    <= 1'b0;
            ar_valid   <= 1'b0;
            b_ready    <= 1'b0;
            r_ready    <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (accept) begin
                        state     <= ST_BUSY;
                        req_ready <= 1'b0;
                        case (req.op)
                            OP_LOAD:  ar_valid <= 1'b1;
                            OP_STORE: begin
                                aw_valid <= 1'b1;
                                w_valid  <= 1'b1;
                            end
                            default:  resp_valid <= 1'b1;   // none op answers at once
                        endcase
                    end
                end
                default: begin
                    if (ar_hs) begin
                        ar_valid <= 1'b0;
                        r_ready  <= 1'b1;
                    end
                    if (wr_hs) begin
                        aw_valid <= 1'b0;
                        w_valid  <= 1'b0;
                        b_ready  <= 1'b1;
                    end
                    if (r_hs || b_hs) begin
                        r_ready    <= 1'b0;
                        b_ready    <= 1'b0;
                        resp_valid <= 1'b1;
                    end
                    if (resp_hs) begin
                        resp_valid <= 1'b0;
                        req_ready  <= 1'b1;
                        state      <= ST_IDLE;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            addr_q <= req.addr;
            aw     <= '{addr: req.addr, size: size};
            ar     <= '{addr: req.addr, size: size};
            w.data <= req.wdata << {offset, 3'b000};    // move into byte lane
            w.strb <= strb_base << offset;
            if (req.op == OP_NONE) begin
                resp <= '{addr: req.addr, data: req.addr, fault: 1'b0};
            end
        end
        if (r_hs) begin
            resp <= '{addr: addr_q, data: r_fault ? 32'h0 : r.data, fault: r_fault};
        end
        if (b_hs) begin
            resp <= '{addr: addr_q, data: 32'h0, fault: b.resp != RESP_OKAY};
        end
    end

    // single outstanding, never a read and a write in flight together
    assert property (@(posedge clk) disable iff (rst) !(aw_valid && ar_valid));

endmodule

/* lsu_axi_pkg.sv */
package lsu_axi_pkg;

    // response codes
    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;
    localparam logic [1:0] RESP_DECERR = 2'b11;

    // transfer size, log2 of bytes
    localparam logic [2:0] SIZE_BYTE = 3'd0;
    localparam logic [2:0] SIZE_HALF = 3'd1;
    localparam logic [2:0] SIZE_WORD = 3'd2;

    typedef struct packed {
        logic [31:0] addr;
        logic [2:0]  size;
    } axi_aw_t;

    typedef struct packed {
        logic [31:0] data;
        logic [3:0]  strb;
    } axi_w_t;

    typedef struct packed {
        logic [1:0] resp;
    } axi_b_t;

    typedef struct packed {
        logic [31:0] addr;
        logic [2:0]  size;
    } axi_ar_t;

    typedef struct packed {
        logic [31:0] data;
        logic [1:0]  resp;
    } axi_r_t;

endpackage

/* lsu_mem.f */
lsu_axi_pkg.sv
lsu_mem_pkg.sv
lsu.sv
axi_bank_router.sv
axi_sram_bank.sv
axi_resp_merge.sv
lsu_mem_top.sv
tb_lsu_mem.sv

/* lsu_mem_pkg.sv */
package lsu_mem_pkg;

    localparam int NUM_BANKS    = 4;
    localparam int BANK_WORDS   = 256;
    localparam int BANK_IDX_W   = $clog2(NUM_BANKS);
    localparam int BANK_SEL_LSB = 10;                   // bits 11:10 pick the bank

    localparam logic [31:0] MEM_BASE  = 32'h8000_0000;
    localparam logic [31:0] MEM_BYTES = 32'(NUM_BANKS * BANK_WORDS * 4);   // 4 KiB

    typedef enum logic [1:0] {
        OP_NONE  = 2'd0,
        OP_LOAD  = 2'd1,
        OP_STORE = 2'd2
    } mem_op_e;

    typedef enum logic [2:0] {
        WIDTH_BYTE = 3'b001,
        WIDTH_HALF = 3'b010,
        WIDTH_WORD = 3'b100
    } mem_width_e;

    typedef struct packed {
        logic [31:0] addr;
        logic [31:0] wdata;
        mem_op_e     op;
        mem_width_e  width;
    } lsu_req_t;

    typedef struct packed {
        logic [31:0] addr;
        logic [31:0] data;
        logic        fault;
    } lsu_resp_t;

    typedef struct packed {
        logic                  dec_err;
        logic [BANK_IDX_W-1:0] bank;
    } route_t;

endpackage

/* lsu_mem_top.sv */
`timescale 1ns/1ps

module lsu_mem_top import lsu_axi_pkg::*, lsu_mem_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  lsu_req_t  req,
    input  logic      req_valid,
    output logic      req_ready,
    output lsu_resp_t resp,
    output logic      resp_valid,
    input  logic      resp_ready
);

    axi_aw_t              aw;
    axi_w_t               w;
    axi_b_t               b;
    axi_ar_t              ar;
    axi_r_t               r;
    logic                 aw_valid;
    logic                 aw_ready;
    logic                 w_valid;
    logic                 w_ready;
    logic                 b_valid;
    logic                 b_ready;
    logic                 ar_valid;
    logic                 ar_ready;
    logic                 r_valid;
    logic                 r_ready;
    axi_aw_t              bank_aw [NUM_BANKS];
    axi_w_t               bank_w [NUM_BANKS];
    axi_b_t               bank_b [NUM_BANKS];
    axi_ar_t              bank_ar [NUM_BANKS];
    axi_r_t               bank_r [NUM_BANKS];
    logic [NUM_BANKS-1:0] bank_aw_valid;
    logic [NUM_BANKS-1:0] bank_aw_ready;
    logic [NUM_BANKS-1:0] bank_w_valid;
    logic [NUM_BANKS-1:0] bank_w_ready;
    logic [NUM_BANKS-1:0] bank_b_valid;
    logic [NUM_BANKS-1:0] bank_b_ready;
    logic [NUM_BANKS-1:0] bank_ar_valid;
    logic [NUM_BANKS-1:0] bank_ar_ready;
    logic [NUM_BANKS-1:0] bank_r_valid;
    logic [NUM_BANKS-1:0] bank_r_ready;
    route_t               route;
    logic                 route_valid;
    logic                 route_done;

    lsu u_lsu (.*);

    axi_bank_router u_router (.*);

    for (genvar i = 0; i < NUM_BANKS; i++) begin : g_bank
        axi_sram_bank u_bank (
            .clk      (clk),
            .rst      (rst),
            .aw       (bank_aw[i]),
            .aw_valid (bank_aw_valid[i]),
            .aw_ready (bank_aw_ready[i]),
            .w        (bank_w[i]),
            .w_valid  (bank_w_valid[i]),
            .w_ready  (bank_w_ready[i]),
            .b        (bank_b[i]),
            .b_valid  (bank_b_valid[i]),
            .b_ready  (bank_b_ready[i]),
            .ar       (bank_ar[i]),
            .ar_valid (bank_ar_valid[i]),
            .ar_ready (bank_ar_ready[i]),
            .r        (bank_r[i]),
            .r_valid  (bank_r_valid[i]),
            .r_ready  (bank_r_ready[i])
        );
    end

    axi_resp_merge u_merge (.*);

endmodule

/* tb_lsu_mem.sv */
`timescale 1ns/1ps

module tb_lsu_mem import lsu_mem_pkg::*; ();

    localparam int NUM_REQS       = 600;
    localparam int POOL_WORDS     = 64;
    localparam int TIMEOUT_CYCLES = (NUM_REQS + 2 * POOL_WORDS) * 40;

    logic      clk;
    logic      rst;
    lsu_req_t  req;
    logic      req_valid;
    logic      req_ready;
    lsu_resp_t resp;
    logic      resp_valid;
    logic      resp_ready;

    integer     seed;
    logic [7:0] model_mem [4096];   // byte image of the 4 KiB map

    lsu_mem_top DUT (
        .clk        (clk),
        .rst        (rst),
        .req        (req),
        .req_valid  (req_valid),
        .req_ready  (req_ready),
        .resp       (resp),
        .resp_valid (resp_valid),
        .resp_ready (resp_ready)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic stop_with_error();
        $display("Testbench failed");
        $fatal(1);
    endtask

    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        $display("timeout, the run did not finish within %0d cycles", TIMEOUT_CYCLES);
        stop_with_error();
    end

    task automatic check_resp(input lsu_resp_t got, input lsu_resp_t exp);
        if (got.addr !== exp.addr) begin
            $display("ERROR resp.addr got %h expected %h", got.addr, exp.addr);
            stop_with_error();
        end
        if (got.data !== exp.data) begin
            $display("ERROR resp.data got %h expected %h at addr %h", got.data, exp.data,
                     exp.addr);
            stop_with_error();
        end
    endtask

    task automatic check_fault(input logic got, input logic exp, input logic [31:0] addr);
        if (got !== exp) begin
            $display("ERROR resp.fault got %h expected %h at addr %h", got, exp, addr);
            stop_with_error();
        end
    endtask

    // 64 words spread over all banks and index bits
    function automatic logic [11:0] pool_offset(input logic [5:0] idx);
        return {idx[5:4], idx[3:0], ~idx[3:0], 2'b00};
    endfunction

    function automatic logic [31:0] fill_word(input logic [31:0] addr);
        return addr * 32'h9e37_79b9 ^ {addr[15:0], addr[31:16]};
    endfunction

    function automatic int width_bytes(input mem_width_e wd);
        case (wd)
            WIDTH_BYTE: return 1;
            WIDTH_HALF: return 2;
            default:    return 4;
        endcase
    endfunction

    function automatic logic [31:0] model_word(input logic [11:0] base);
        return {model_mem[base + 12'd3], model_mem[base + 12'd2],
                model_mem[base + 12'd1], model_mem[base]};
    endfunction

    // expected result, stores update the model only when they succeed
    task automatic predict(input lsu_req_t rq, output lsu_resp_t exp);
        logic [31:0] diff;
        logic [11:0] byte_idx;
        logic        mapped;
        logic        aligned;
        int          nb;
        diff      = rq.addr - MEM_BASE;
        nb        = width_bytes(rq.width);
        mapped    = rq.addr >= MEM_BASE && rq.addr < MEM_BASE + MEM_BYTES;
        aligned   = (rq.addr[1:0] & 2'(nb - 1)) == 2'b00;
        exp.addr  = rq.addr;
        exp.data  = 32'h0;
        exp.fault = 1'b0;
        if (rq.op == OP_NONE) begin
            exp.data = rq.addr;
        end else if (!mapped || !aligned) begin
            exp.fault = 1'b1;
        end else if (rq.op == OP_LOAD) begin
            exp.data = model_word({diff[11:2], 2'b00});    // raw bus word
        end else begin
            for (int k = 0; k < nb; k++) begin
                byte_idx            = diff[11:0] + 12'(k);
                model_mem[byte_idx] = rq.wdata[8*k +: 8];
            end
        end
    endtask

    task automatic make_request(output lsu_req_t rq);
        logic [31:0] rnd;
        logic [31:0] pick;
        logic [11:0] off;
        rnd  = $random(seed);
        pick = rnd % 100;
        if (pick < 20) begin
            rq.op = OP_NONE;
        end else if (pick < 60) begin
            rq.op = OP_LOAD;
        end else begin
            rq.op = OP_STORE;
        end
        rnd = $random(seed);
        case (rnd % 3)
            32'd0:   rq.width = WIDTH_BYTE;
            32'd1:   rq.width = WIDTH_HALF;
            default: rq.width = WIDTH_WORD;
        endcase
        rq.wdata = $random(seed);
        rnd      = $random(seed);
        pick     = rnd % 10;
        off      = pool_offset(rnd[13:8]);
        case (rq.width)
            WIDTH_BYTE: off[1:0] = rnd[1:0];
            WIDTH_HALF: off[1:0] = {rnd[1], 1'b0};
            default:    off[1:0] = 2'b00;
        endcase
        if (pick == 1) begin                // misaligned
            if (rq.width == WIDTH_BYTE) begin
                rq.width = WIDTH_HALF;
            end
            if (rq.width == WIDTH_HALF) begin
                off[1:0] = {rnd[1], 1'b1};
            end else begin
                off[1:0] = (rnd[1:0] == 2'b00) ? 2'b10 : rnd[1:0];
            end
        end
        rq.addr = MEM_BASE + {20'h0, off};
        if (pick == 0) begin                // outside the map
            if (rnd[31]) begin
                rq.addr = {1'b0, rnd[30:0]};
            end else begin
                rq.addr = MEM_BASE + MEM_BYTES + {16'h0, rnd[23:8]};
            end
        end
    endtask

    // one request through the DUT, result held under random back-pressure
    task automatic run_request(input lsu_req_t rq);
        lsu_resp_t   exp;
        lsu_resp_t   held;
        logic        seen;
        logic        done;
        logic [31:0] rnd;
        predict(rq, exp);
        req       = rq;
        req_valid = 1'b1;
        while (!req_ready) @(negedge clk);
        @(negedge clk);
        req_valid = 1'b0;
        if (rq.op == OP_NONE && !resp_valid) begin
            $display("none op at %h did not answer in the cycle after acceptance", rq.addr);
            stop_with_error();
        end
        seen = 1'b0;
        done = 1'b0;
        while (!done) begin
            if (resp_valid) begin
                if (!seen) begin
                    check_resp(resp, exp);
                    check_fault(resp.fault, exp.fault, rq.addr);
                    held = resp;
                    seen = 1'b1;
                end else if (resp !== held) begin
                    $display("result for %h changed while resp_ready was low", rq.addr);
                    stop_with_error();
                end
                if (req_ready) begin
                    $display("req_ready rose while the result for %h was pending", rq.addr);
                    stop_with_error();
                end
            end else if (seen) begin
                $display("resp_valid dropped before the result for %h was taken", rq.addr);
                stop_with_error();
            end
            rnd        = $random(seed);
            resp_ready = rnd[1:0] != 2'b00;
            done       = resp_valid && resp_ready;
            @(negedge clk);
        end
        resp_ready = 1'b0;
    endtask

    initial begin
        lsu_req_t rq;
        seed       = 32'h6bfe6a32;
        rst        = 1'b1;
        req        = '0;
        req_valid  = 1'b0;
        resp_ready = 1'b0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        if (!req_ready || resp_valid) begin
            $display("lsu is not idle after reset");
            stop_with_error();
        end
        for (int i = 0; i < POOL_WORDS; i++) begin     // word fill of the pool
            rq.addr  = MEM_BASE + {20'h0, pool_offset(6'(i))};
            rq.wdata = fill_word(rq.addr);
            rq.op    = OP_STORE;
            rq.width = WIDTH_WORD;
            run_request(rq);
        end
        for (int i = 0; i < POOL_WORDS; i++) begin     // read back
            rq.addr  = MEM_BASE + {20'h0, pool_offset(6'(i))};
            rq.wdata = 32'h0;
            rq.op    = OP_LOAD;
            rq.width = WIDTH_WORD;
            run_request(rq);
        end
        for (int n = 0; n < NUM_REQS; n++) begin
            make_request(rq);
            run_request(rq);
        end
        $display("Testbench passed");
        $finish;
    end

endmodule
